// File: soc_ctrl_defines.svh
`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

// --------------------
// CSR bus geometry
// --------------------
`define CSR_ADDR_W 14
// Bank select sits in the top bits
`define CSR_BANK_W 4
`define CSR_REG_W 10

// Reset conditioner counters, simulation size
`define DEBOUNCE_W 8
// Top bit of this one releases the peripheral reset
`define PRST_W 6

// Bank numbers on the CSR bus
`define CSR_BANK_GPIO 4'd1
`define CSR_BANK_TIMER 4'd2

// ASCII "X401"
`define SYSTEM_ID 32'h58343031

// --------------------
// Register indices
// --------------------
// GPIO bank
`define REG_GPIO_IN 10'd0
`define REG_GPIO_OUT 10'd1
`define REG_GPIO_IRQ_EN 10'd2
`define REG_SYSTEM_ID 10'd3
`define REG_HARD_RESET 10'd4

// Timer bank
`define REG_TIMER_CTRL 10'd0
`define REG_TIMER_COMPARE 10'd1
`define REG_TIMER_COUNTER 10'd2

`endif

// File: soc_ctrl_pkg.sv
`include "soc_ctrl_defines.svh"

package soc_ctrl_pkg;

	// --------------------
	// CSR bus types
	// --------------------
	// Full CSR address, bank field above register field
	typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [`CSR_BANK_W-1:0] csr_bank_t;
	typedef logic [`CSR_REG_W-1:0] csr_reg_t;
	// Read and write data share one width
	typedef logic [31:0] csr_data_t;

	// --------------------
	// GPIO types
	// --------------------
	// Switches (8) above buttons (5)
	typedef logic [12:0] gpio_in_t;
	// LEDs, button LEDs and LCD lines
	typedef logic [13:0] gpio_out_t;

	// --------------------
	// Bridge FSM
	// --------------------
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		READ_WAIT,
		ACK
	} brg_state_t;

endpackage

// File: csr_if.sv
// Shared CSR bus between the bridge and the register banks
interface csr_if
	import soc_ctrl_pkg::*;
();

	// Master side
	csr_addr_t csr_a;
	logic csr_we;
	csr_data_t csr_dw;

	// One registered read-data line per bank
	csr_data_t csr_dr_gpio;
	csr_data_t csr_dr_timer;

	// Bridge drives the access, sees every bank
	modport bridge (
		output csr_a, csr_we, csr_dw,
		input csr_dr_gpio, csr_dr_timer
	);

	// Banks only drive their own read data
	modport gpio_bank (input csr_a, csr_we, csr_dw, output csr_dr_gpio);
	modport timer_bank (input csr_a, csr_we, csr_dw, output csr_dr_timer);

endinterface

// File: reset_ctrl.sv
`include "soc_ctrl_defines.svh"

module reset_ctrl (
	input logic sys_clk,
	input logic reset_i,
	input logic hard_reset_i,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	// Pin synchronizer stages
	logic rst_meta;
	logic rst_sync;

	logic [`DEBOUNCE_W-1:0] debounce_cnt;
	logic [`PRST_W-1:0] prst_cnt;

	// --------------------
	// Synchronizer
	// --------------------
	always_ff @(posedge sys_clk) begin
		rst_meta <= reset_i;
		rst_sync <= rst_meta;
	end

	// --------------------
	// Debounce
	// --------------------
	// Reloaded by the pin or by a software hard reset
	// Holds system reset until it drains
	always_ff @(posedge sys_clk) begin
		if (rst_sync | hard_reset_i) begin
			debounce_cnt <= '1;
		end else if (debounce_cnt != '0) begin
			debounce_cnt <= debounce_cnt - 1'b1;
		end
		sys_rst_o <= (debounce_cnt != '0);
	end

	// --------------------
	// Peripheral reset
	// --------------------
	// Only the pin clears it, so hard reset leaves peripherals alone
	// Short count, released well before the system reset
	always_ff @(posedge sys_clk) begin
		if (rst_sync) begin
			prst_cnt <= '0;
		end else if (!prst_cnt[`PRST_W-1]) begin
			prst_cnt <= prst_cnt + 1'b1;
		end
	end

	// Top bit stays set once reached
	assign periph_rst_n_o = prst_cnt[`PRST_W-1];

endmodule

// File: wb_csr_bridge.sv
`include "soc_ctrl_defines.svh"

module wb_csr_bridge
	import soc_ctrl_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	// Bus slave, byte addressed
	input logic [31:0] wb_adr_i,
	input logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic wb_ack_o,
	// CSR master side
	csr_if.bridge csr
);

	brg_state_t state;
	// Marks the IDLE cycle right after ack
	logic ack_q;
	logic start;

	// New request, blocked just after an ack
	assign start = (state == IDLE) & wb_cyc_i & wb_stb_i & ~ack_q;

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= IDLE;
			wb_ack_o <= 1'b0;
			ack_q <= 1'b0;
			csr.csr_we <= 1'b0;
		end else begin
			ack_q <= wb_ack_o;
			// Single-cycle pulses by default
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state <= ACCESS;
						csr.csr_we <= wb_we_i;
					end
				end
				ACCESS: begin
					// Writes land at this edge, reads need the bank register
					if (wb_we_i) begin
						state <= ACK;
						wb_ack_o <= 1'b1;
					end else begin
						state <= READ_WAIT;
					end
				end
				READ_WAIT: begin
					state <= ACK;
					wb_ack_o <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// --------------------
	// Address and data path
	// --------------------
	always_ff @(posedge sys_clk) begin
		// Address and data only live for the ACCESS cycle
		csr.csr_a <= '0;
		csr.csr_dw <= '0;
		if (start) begin
			// Word address from byte address
			csr.csr_a <= wb_adr_i[15:2];
			csr.csr_dw <= wb_dat_i;
		end
		// Unselected banks return zero, so OR is enough
		if (state == READ_WAIT) begin
			wb_dat_o <= csr.csr_dr_gpio | csr.csr_dr_timer;
		end
	end

endmodule

// File: gpio_regs.sv
`include "soc_ctrl_defines.svh"

module gpio_regs
	import soc_ctrl_pkg::*;
#(
	parameter csr_bank_t csr_bank = `CSR_BANK_GPIO
) (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_if.gpio_bank csr,
	input gpio_in_t gpio_in_i,
	output gpio_out_t gpio_out_o,
	output logic irq_o,
	output logic hard_reset_o
);

	// Address decode
	csr_bank_t bank_sel;
	csr_reg_t reg_idx;
	logic csr_selected;

	// Input synchronizer and previous value
	gpio_in_t in_meta;
	gpio_in_t in_sync;
	gpio_in_t in_prev;

	gpio_in_t irq_en;

	assign bank_sel = csr.csr_a[`CSR_ADDR_W-1 -: `CSR_BANK_W];
	assign reg_idx = csr.csr_a[`CSR_REG_W-1:0];
	assign csr_selected = (bank_sel == csr_bank);

	// --------------------
	// Inputs and interrupt
	// --------------------
	always_ff @(posedge sys_clk) begin
		in_meta <= gpio_in_i;
		in_sync <= in_meta;
		in_prev <= in_sync;
	end

	// Pulse on any enabled bit that toggled
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			irq_o <= 1'b0;
		end else begin
			irq_o <= |((in_sync ^ in_prev) & irq_en);
		end
	end

	// --------------------
	// CSR writes
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			irq_en <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= 1'b0;
			if (csr_selected & csr.csr_we) begin
				case (reg_idx)
					`REG_GPIO_OUT: gpio_out_o <= csr.csr_dw[13:0];
					`REG_GPIO_IRQ_EN: irq_en <= csr.csr_dw[12:0];
					// Data ignored, any write triggers it
					`REG_HARD_RESET: hard_reset_o <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// --------------------
	// CSR reads
	// --------------------
	// Registered, zero while another bank is addressed
	always_ff @(posedge sys_clk) begin
		csr.csr_dr_gpio <= '0;
		if (csr_selected) begin
			case (reg_idx)
				`REG_GPIO_IN: csr.csr_dr_gpio <= csr_data_t'(in_sync);
				`REG_GPIO_OUT: csr.csr_dr_gpio <= csr_data_t'(gpio_out_o);
				`REG_GPIO_IRQ_EN: csr.csr_dr_gpio <= csr_data_t'(irq_en);
				`REG_SYSTEM_ID: csr.csr_dr_gpio <= `SYSTEM_ID;
				default: csr.csr_dr_gpio <= '0;
			endcase
		end
	end

endmodule

// File: timer_regs.sv
`include "soc_ctrl_defines.svh"

module timer_regs
	import soc_ctrl_pkg::*;
#(
	parameter csr_bank_t csr_bank = `CSR_BANK_TIMER
) (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_if.timer_bank csr,
	output logic irq_o
);

	csr_bank_t bank_sel;
	csr_reg_t reg_idx;
	logic csr_selected;
	logic csr_write;

	// CONTROL fields
	logic timer_en;
	logic autorestart;

	csr_data_t timer_compare;
	csr_data_t timer_cnt;

	assign bank_sel = csr.csr_a[`CSR_ADDR_W-1 -: `CSR_BANK_W];
	assign reg_idx = csr.csr_a[`CSR_REG_W-1:0];
	assign csr_selected = (bank_sel == csr_bank);
	assign csr_write = csr_selected & csr.csr_we;

	// --------------------
	// Counter and writes
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			timer_en <= 1'b0;
			autorestart <= 1'b0;
			timer_compare <= '0;
			timer_cnt <= '0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			// Count first, a CSR write below takes priority
			if (timer_en) begin
				if (timer_cnt == timer_compare) begin
					timer_cnt <= '0;
					irq_o <= 1'b1;
					// One-shot stops here
					timer_en <= autorestart;
				end else begin
					timer_cnt <= timer_cnt + 32'd1;
				end
			end
			if (csr_write) begin
				case (reg_idx)
					`REG_TIMER_CTRL: begin
						timer_en <= csr.csr_dw[0];
						autorestart <= csr.csr_dw[1];
					end
					`REG_TIMER_COMPARE: timer_compare <= csr.csr_dw;
					`REG_TIMER_COUNTER: timer_cnt <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// --------------------
	// CSR reads
	// --------------------
	always_ff @(posedge sys_clk) begin
		csr.csr_dr_timer <= '0;
		if (csr_selected) begin
			case (reg_idx)
				`REG_TIMER_CTRL: csr.csr_dr_timer <= {30'd0, autorestart, timer_en};
				`REG_TIMER_COMPARE: csr.csr_dr_timer <= timer_compare;
				`REG_TIMER_COUNTER: csr.csr_dr_timer <= timer_cnt;
				default: csr.csr_dr_timer <= '0;
			endcase
		end
	end

endmodule

// File: soc_ctrl_top.sv
`include "soc_ctrl_defines.svh"

module soc_ctrl_top
	import soc_ctrl_pkg::*;
(
	input logic sys_clk,
	input logic reset_i,
	// Bus slave
	input logic [31:0] wb_adr_i,
	input logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic wb_ack_o,
	// Board inputs
	input logic [4:0] btn_i,
	input logic [7:0] dipsw_i,
	// Board outputs
	output logic [1:0] led_o,
	output logic [4:0] btnled_o,
	output logic lcd_e_o,
	output logic lcd_rs_o,
	output logic lcd_rw_o,
	output logic [3:0] lcd_d_o,
	// Interrupts and peripheral reset
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	logic hard_reset;
	gpio_out_t gpio_out;

	csr_if csr ();

	// --------------------
	// Reset
	// --------------------
	reset_ctrl u_reset_ctrl (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst),
		.periph_rst_n_o(periph_rst_n_o)
	);

	// --------------------
	// Bus to CSR
	// --------------------
	wb_csr_bridge u_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_o(wb_ack_o),
		.csr(csr.bridge)
	);

	// --------------------
	// Register banks
	// --------------------
	gpio_regs #(
		.csr_bank(`CSR_BANK_GPIO)
	) u_gpio (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr.gpio_bank),
		.gpio_in_i({dipsw_i, btn_i}),
		.gpio_out_o(gpio_out),
		.irq_o(gpio_irq_o),
		.hard_reset_o(hard_reset)
	);

	timer_regs #(
		.csr_bank(`CSR_BANK_TIMER)
	) u_timer (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr.timer_bank),
		.irq_o(timer_irq_o)
	);

	// GPIO output register to board pins
	assign led_o = gpio_out[1:0];
	assign btnled_o = gpio_out[6:2];
	assign lcd_e_o = gpio_out[7];
	assign lcd_rs_o = gpio_out[8];
	assign lcd_rw_o = gpio_out[9];
	assign lcd_d_o = gpio_out[13:10];

endmodule

// File: tb_clk_gen.sv
// Free-running testbench clock
module tb_clk_gen #(
	parameter int period_ns = 4
) (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// Starts low, toggles every half period
	initial begin
		clk_o = 1'b0;
		forever begin
			#(period_ns / 2) clk_o = ~clk_o;
		end
	end

endmodule

// File: soc_ctrl_assertions.sv
// Bus protocol checks on the bridge slave port
module soc_ctrl_assertions (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic we_i,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	// Bridge leaves IDLE on this edge
	input logic start_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// --------------------
	// Handshake shape
	// --------------------
	ack_single_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		ack_i |=> !ack_i)
		else $error("bus ack held for more than one cycle");

	ack_inside_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		ack_i |-> (cyc_i && stb_i))
		else $error("bus ack outside of an active bus cycle");

	// --------------------
	// Latency
	// --------------------
	// Write acked two cycles after the request, read three
	write_latency: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		(start_i && we_i) |=> !ack_i ##1 ack_i)
		else $error("write ack not exactly two cycles after the request");

	read_latency: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		(start_i && !we_i) |=> !ack_i [*2] ##1 ack_i)
		else $error("read ack not exactly three cycles after the request");

	// Checked during reset itself
	no_ack_in_reset: assert property (@(posedge sys_clk)
		sys_rst_i |-> !ack_i)
		else $error("bus ack while the system reset is high");

endmodule

bind wb_csr_bridge soc_ctrl_assertions u_bus_checks (
	.sys_clk(sys_clk),
	.sys_rst_i(sys_rst_i),
	.we_i(wb_we_i),
	.cyc_i(wb_cyc_i),
	.stb_i(wb_stb_i),
	.ack_i(wb_ack_o),
	.start_i(start)
);

// File: tb_soc_ctrl.sv
`include "soc_ctrl_defines.svh"

module tb_soc_ctrl;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ack_timeout = 1000;
	localparam int stim_depth = 64;

	logic sys_clk;
	logic reset_i;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_ack_o;
	logic [4:0] btn_i;
	logic [7:0] dipsw_i;
	logic [1:0] led_o;
	logic [4:0] btnled_o;
	logic lcd_e_o;
	logic lcd_rs_o;
	logic lcd_rw_o;
	logic [3:0] lcd_d_o;
	logic gpio_irq_o;
	logic timer_irq_o;
	logic periph_rst_n_o;

	// GPIO output register rebuilt from the board pins
	logic [13:0] pin_word;

	// Op in [71:64] with first operand in [63:32] and second in [31:0]
	logic [71:0] stim_mem [stim_depth];

	// Pulses seen per interrupt (0 gpio and 1 timer)
	int irq_cnt [2] = '{0, 0};
	// Pulses already consumed by interrupt waits
	int irq_taken [2] = '{0, 0};
	logic periph_up = 1'b0;

	assign pin_word = {lcd_d_o, lcd_rw_o, lcd_rs_o, lcd_e_o, btnled_o, led_o};

	tb_clk_gen #(
		.period_ns(4)
	) u_clk_gen (
		.clk_o(sys_clk)
	);

	soc_ctrl_top DUT (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_o(wb_ack_o),
		.btn_i(btn_i),
		.dipsw_i(dipsw_i),
		.led_o(led_o),
		.btnled_o(btnled_o),
		.lcd_e_o(lcd_e_o),
		.lcd_rs_o(lcd_rs_o),
		.lcd_rw_o(lcd_rw_o),
		.lcd_d_o(lcd_d_o),
		.gpio_irq_o(gpio_irq_o),
		.timer_irq_o(timer_irq_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	// --------------------
	// Failure reporting
	// --------------------
	task automatic flag_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_run(input string what);
		$display("Run stopped at %0t ns: %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	// --------------------
	// Monitors
	// --------------------
	always @(posedge sys_clk) begin
		if (gpio_irq_o === 1'b1) begin
			irq_cnt[0]++;
		end
		if (timer_irq_o === 1'b1) begin
			irq_cnt[1]++;
		end
	end

	// Peripheral reset stays high once released and through a hard reset
	always @(negedge sys_clk) begin
		if (periph_up) begin
			assert (periph_rst_n_o === 1'b1)
				else flag_mismatch("periph_rst_n_o after release", periph_rst_n_o, 1);
		end
		if (periph_rst_n_o === 1'b1) begin
			periph_up = 1'b1;
		end
	end

	// --------------------
	// Bus master
	// --------------------
	// Called and returns on a falling edge
	task automatic bus_access(input logic we, input logic [31:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat, output int cycles);
		int wait_cnt;
		wait_cnt = 1;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		wb_we_i = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		@(negedge sys_clk);
		while (wb_ack_o !== 1'b1 && wait_cnt < ack_timeout) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		assert (wb_ack_o === 1'b1) else abort_run("timed out waiting for the bus ack");
		rdat = wb_dat_o;
		cycles = wait_cnt;
		// Hold the cycle across the edge that samples ack
		@(negedge sys_clk);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	// Byte address of a CSR with the bank above the register index in bits 15 to 2
	function automatic logic [31:0] csr_byte_adr(input logic [3:0] bank,
			input logic [9:0] idx);
		return {16'd0, bank, idx, 2'b00};
	endfunction

	// Reads the system ID until it answers and each read has its own timeout
	task automatic poll_system_id(output int cycles);
		logic [31:0] rdat;
		int polls;
		polls = 0;
		rdat = '0;
		while (rdat !== `SYSTEM_ID && polls < 4) begin
			bus_access(1'b0, csr_byte_adr(4'd1, 10'd3), '0, rdat, cycles);
			polls++;
		end
		assert (rdat === `SYSTEM_ID) else flag_mismatch("system ID", rdat, `SYSTEM_ID);
		assert (periph_rst_n_o === 1'b1)
			else flag_mismatch("periph_rst_n_o at system ID ack", periph_rst_n_o, 1);
	endtask

	task automatic wait_irq_pulse(input int idx, input int limit);
		int wait_cnt;
		wait_cnt = 0;
		while (irq_cnt[idx] <= irq_taken[idx] && wait_cnt < limit) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		assert (irq_cnt[idx] > irq_taken[idx])
			else abort_run("timed out waiting for an interrupt pulse");
		irq_taken[idx]++;
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		logic [7:0] op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] rdat;
		int cycles;
		reset_i = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		btn_i = '0;
		dipsw_i = '0;
		$readmemh("soc_ctrl_stim.txt", stim_mem);

		// Pin reset for four cycles
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		reset_i = 1'b0;
		// Everything sits in reset once the synchronizer has passed it on
		repeat (4) @(negedge sys_clk);
		assert ({wb_ack_o, gpio_irq_o, timer_irq_o, periph_rst_n_o} === 4'b0000)
			else flag_mismatch("ack, irqs, periph reset in reset",
				{wb_ack_o, gpio_irq_o, timer_irq_o, periph_rst_n_o}, 0);
		assert (pin_word === '0) else flag_mismatch("board pins in reset", pin_word, 0);

		poll_system_id(cycles);
		assert ({gpio_irq_o, timer_irq_o, pin_word} === '0)
			else flag_mismatch("irqs and pins after reset", {gpio_irq_o, timer_irq_o, pin_word}, 0);

		for (int i = 0; i < stim_depth; i++) begin
			op = stim_mem[i][71:64];
			arg_a = stim_mem[i][63:32];
			arg_b = stim_mem[i][31:0];
			if (op === 8'h00 || $isunknown(op)) begin
				break;
			end
			case (op)
				8'h01: bus_access(1'b1, arg_a, arg_b, rdat, cycles);
				8'h02: begin
					bus_access(1'b0, arg_a, '0, rdat, cycles);
					assert (rdat === arg_b) else flag_mismatch($sformatf("read of %h", arg_a),
						rdat, arg_b);
				end
				8'h03: begin
					btn_i = arg_a[4:0];
					dipsw_i = arg_b[7:0];
					// Two synchronizer stages plus the read register
					repeat (4) @(negedge sys_clk);
				end
				8'h04: wait_irq_pulse(arg_a[0], arg_b);
				8'h05: begin
					repeat (arg_b) @(negedge sys_clk);
					assert (irq_cnt[arg_a[0]] == irq_taken[arg_a[0]])
						else flag_mismatch("pulses in quiet window", irq_cnt[arg_a[0]],
							irq_taken[arg_a[0]]);
				end
				8'h06: begin
					bus_access(1'b1, csr_byte_adr(4'd1, 10'd4), 32'd1, rdat, cycles);
					poll_system_id(cycles);
					// Debounce counter holds the next access back
					assert (cycles >= (1 << `DEBOUNCE_W))
						else flag_mismatch("wait after hard reset", cycles, 1 << `DEBOUNCE_W);
				end
				8'h07: begin
					assert (pin_word === arg_b[13:0])
						else flag_mismatch("board pins", pin_word, arg_b);
				end
				default: abort_run($sformatf("unknown stimulus op %h in entry %0d", op, i));
			endcase
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: soc_ctrl_stim.txt
// Columns op_a_b in hex: 01 write adr data, 02 read adr expected, 03 inputs btn sw
// 04 irq wait (0 gpio, 1 timer) timeout, 05 quiet irq window, 06 hard reset, 07 pins, 00 end
02_0000100c_58343031
01_00001004_ffffffff
07_00000000_00003fff
02_00001004_00003fff
01_00001004_000025a6
07_00000000_000025a6
02_00001004_000025a6
03_00000015_000000a5
02_00001000_000014b5
02_00003000_00000000
02_00000010_00000000
01_00001008_0000001f
02_00001008_0000001f
03_00000014_000000a5
04_00000000_00000010
03_00000014_00000025
05_00000000_00000010
01_00002004_00000010
01_00002000_00000001
04_00000001_00000040
02_00002000_00000000
01_00002000_00000003
04_00000001_00000040
04_00000001_00000040
01_00002000_00000000
02_00002000_00000000
06_00000000_00000000
02_00001004_00000000
07_00000000_00000000
02_00001008_00000000
00_00000000_00000000

// File: soc_ctrl_top.f
+incdir+.
soc_ctrl_pkg.sv
csr_if.sv
reset_ctrl.sv
wb_csr_bridge.sv
gpio_regs.sv
timer_regs.sv
soc_ctrl_top.sv
tb_clk_gen.sv
soc_ctrl_assertions.sv
tb_soc_ctrl.sv
